// File: src/audio_defines.svh
`ifndef AUDIO_DEFINES_SVH
`define AUDIO_DEFINES_SVH

// Sample widths on both sides of the serial link
`define AUDIO_SAMPLE_W 16    // One codec sample
`define AUDIO_FIR_W 32       // Filter output word

// Clock division, counted in system clock cycles
`define AUDIO_BCLK_HALF 8    // Bit clock half period

// Left/right half period.
// Must be an even multiple of AUDIO_BCLK_HALF so that LRCLK moves on a BCLK fall
`define AUDIO_LRCLK_HALF 512

// 512 / 8 gives 32 bit-clock periods per half frame,
// which leaves room for one 16-bit sample plus the I2S delay bit

`endif

// File: src/audio_pkg.sv
package audio_pkg;

  `include "audio_defines.svh"

  // Codec sample as seen on the ADC and DAC lines
  typedef logic [`AUDIO_SAMPLE_W-1:0] sample_t;

  // Word delivered by the filter, upper bits carry the sample
  typedef logic [`AUDIO_FIR_W-1:0] fir_word_t;

  // Configuration register map
  typedef enum logic [1:0] {
    REG_CTRL  = 2'd0,  // Bit 0 mute, bit 1 loopback
    REG_COUNT = 2'd1   // Received sample counter, read only
  } reg_addr_e;

  // Bit positions inside REG_CTRL
  localparam int unsigned CTRL_MUTE_BIT     = 0;
  localparam int unsigned CTRL_LOOPBACK_BIT = 1;

endpackage

// File: src/i2s_clock_gen.sv
`timescale 1ns/1ps

`include "audio_defines.svh"

module i2s_clock_gen (
  input  logic clk_i,
  input  logic rst_ni,
  output logic ac_mclk,
  output logic ac_bclk,
  output logic ac_lrclk,
  output logic lrclk,
  output logic bclk_rise,
  output logic bclk_fall,
  output logic lrclk_rise,
  output logic lrclk_fall
);

  localparam int unsigned BCLK_CNT_W  = $clog2(`AUDIO_BCLK_HALF);
  localparam int unsigned LRCLK_CNT_W = $clog2(`AUDIO_LRCLK_HALF);

  localparam logic [BCLK_CNT_W-1:0]  BCLK_RELOAD  = BCLK_CNT_W'(`AUDIO_BCLK_HALF - 1);
  localparam logic [LRCLK_CNT_W-1:0] LRCLK_RELOAD = LRCLK_CNT_W'(`AUDIO_LRCLK_HALF - 1);

  logic [BCLK_CNT_W-1:0]  bclk_cnt;
  logic [LRCLK_CNT_W-1:0] lrclk_cnt;
  logic                   bclk_q;
  logic                   lrclk_q;

  // Master clock runs at half the system clock
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) ac_mclk <= 1'b0;
    else         ac_mclk <= ~ac_mclk;
  end

  // Bit clock divider
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bclk_cnt <= BCLK_RELOAD;
      bclk_q   <= 1'b0;
    end else if (bclk_cnt == '0) begin
      bclk_cnt <= BCLK_RELOAD;
      bclk_q   <= ~bclk_q;
    end else begin
      bclk_cnt <= bclk_cnt - 1'b1;
    end
  end

  // Left/right divider, starts together with the bit clock divider
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lrclk_cnt <= LRCLK_RELOAD;
      lrclk_q   <= 1'b0;
    end else if (lrclk_cnt == '0) begin
      lrclk_cnt <= LRCLK_RELOAD;
      lrclk_q   <= ~lrclk_q;
    end else begin
      lrclk_cnt <= lrclk_cnt - 1'b1;
    end
  end

  // Strobes fire one cycle ahead of the clock edge they announce
  assign bclk_rise  = (bclk_cnt == '0) && !bclk_q;
  assign bclk_fall  = (bclk_cnt == '0) && bclk_q;
  assign lrclk_rise = (lrclk_cnt == '0) && !lrclk_q;
  assign lrclk_fall = (lrclk_cnt == '0) && lrclk_q;

  assign ac_bclk  = bclk_q;
  assign ac_lrclk = lrclk_q;
  assign lrclk    = lrclk_q;  // Level copy for channel tagging

endmodule

// File: src/i2s_receiver.sv
`timescale 1ns/1ps

`include "audio_defines.svh"

module i2s_receiver (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               ac_adc_sdata,
  input  logic               lrclk,
  input  logic               bclk_rise,
  input  logic               lrclk_rise,
  input  logic               lrclk_fall,
  output audio_pkg::sample_t rx_data,
  output logic               rx_valid,
  output logic               rx_right
);

  import audio_pkg::*;

  // Count value seen on the rise that follows the last data bit
  localparam logic [4:0] CAPTURE_CNT = 5'(`AUDIO_SAMPLE_W + 1);

  logic [4:0] rise_cnt;
  sample_t    shift_q;
  logic       in_window;

  // Rise 1 carries the I2S delay slot, data follows on the next 16 rises
  assign in_window = (rise_cnt != '0) && (rise_cnt <= 5'(`AUDIO_SAMPLE_W));

  // Rise counter saturates, so nothing is captured before the first frame edge
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rise_cnt <= '1;
    end else if (lrclk_rise || lrclk_fall) begin
      rise_cnt <= '0;
    end else if (bclk_rise && (rise_cnt != '1)) begin
      rise_cnt <= rise_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      shift_q <= '0;
    end else if (lrclk_rise || lrclk_fall) begin
      shift_q <= '0;
    end else if (bclk_rise && in_window) begin
      shift_q <= {shift_q[`AUDIO_SAMPLE_W-2:0], ac_adc_sdata};  // MSB first
    end
  end

  // Hand the finished word over together with its channel
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rx_data  <= '0;
      rx_valid <= 1'b0;
      rx_right <= 1'b0;
    end else begin
      rx_valid <= 1'b0;
      if (bclk_rise && (rise_cnt == CAPTURE_CNT)) begin
        rx_data  <= shift_q;
        rx_valid <= 1'b1;
        rx_right <= lrclk;  // High level marks the right channel
      end
    end
  end

endmodule

// File: src/i2s_transmitter.sv
`timescale 1ns/1ps

`include "audio_defines.svh"

module i2s_transmitter (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  audio_pkg::fir_word_t tx_data,
  input  logic                 tx_valid,
  input  audio_pkg::sample_t   rx_data,
  input  logic                 mute,
  input  logic                 loopback,
  input  logic                 bclk_fall,
  input  logic                 lrclk_rise,
  input  logic                 lrclk_fall,
  output logic                 ac_dac_sdata
);

  import audio_pkg::*;

  localparam int unsigned PAD_W = `AUDIO_FIR_W - `AUDIO_SAMPLE_W;

  logic                 pending;
  fir_word_t            held_word;
  logic                 lr_edge;
  logic [`AUDIO_FIR_W:0] shift_q;  // Extra MSB is the I2S delay bit

  assign lr_edge = lrclk_rise || lrclk_fall;

  // Keep the latest filter word until the next half frame takes it
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pending   <= 1'b0;
      held_word <= '0;
    end else begin
      if (lr_edge && !mute && !loopback) pending <= 1'b0;  // Consumed by the shifter
      if (tx_valid) begin
        pending   <= 1'b1;
        held_word <= tx_data;
      end
    end
  end

  // Load at the half frame boundary and shift on each later bit clock fall
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      shift_q <= '0;
    end else if (lr_edge) begin
      if (mute) begin
        shift_q <= '0;
      end else if (loopback) begin
        shift_q <= {1'b0, rx_data, {PAD_W{1'b0}}};
      end else if (pending) begin
        shift_q <= {1'b0, held_word};
      end
      // Nothing new to send so the old contents stay in place
    end else if (bclk_fall) begin
      shift_q <= {shift_q[`AUDIO_FIR_W-1:0], 1'b0};
    end
  end

  assign ac_dac_sdata = shift_q[`AUDIO_FIR_W];

endmodule

// File: src/audio_ctrl_regs.sv
`timescale 1ns/1ps

module audio_ctrl_regs (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 cfg_we,
  input  audio_pkg::reg_addr_e cfg_addr,
  input  logic [7:0]           cfg_wdata,
  input  logic                 rx_valid,
  output logic [7:0]           cfg_rdata,
  output logic                 mute,
  output logic                 loopback
);

  import audio_pkg::*;

  logic [1:0] ctrl_q;
  logic [7:0] sample_cnt;

  // Control register, the only writable location
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ctrl_q <= '0;
    end else if (cfg_we && (cfg_addr == REG_CTRL)) begin
      ctrl_q <= cfg_wdata[1:0];
    end
  end

  // Received samples, wraps at 256
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sample_cnt <= '0;
    end else if (rx_valid) begin
      sample_cnt <= sample_cnt + 8'd1;
    end
  end

  assign mute     = ctrl_q[CTRL_MUTE_BIT];
  assign loopback = ctrl_q[CTRL_LOOPBACK_BIT];

  // Read path is combinational
  always_comb begin
    cfg_rdata = '0;
    case (cfg_addr)
      REG_CTRL:  cfg_rdata = {6'b0, ctrl_q};
      REG_COUNT: cfg_rdata = sample_cnt;
      default:   cfg_rdata = '0;  // Unmapped addresses read zero
    endcase
  end

endmodule

// File: src/i2s_codec_top.sv
`timescale 1ns/1ps

module i2s_codec_top (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  // Codec side
  output logic                 ac_mclk,
  output logic                 ac_bclk,
  output logic                 ac_lrclk,
  input  logic                 ac_adc_sdata,
  output logic                 ac_dac_sdata,
  // Hardware side
  input  audio_pkg::fir_word_t tx_data,
  input  logic                 tx_valid,
  output audio_pkg::sample_t   rx_data,
  output logic                 rx_valid,
  output logic                 rx_right,
  // Configuration
  input  logic                 cfg_we,
  input  audio_pkg::reg_addr_e cfg_addr,
  input  logic [7:0]           cfg_wdata,
  output logic [7:0]           cfg_rdata
);

  logic lrclk;
  logic bclk_rise;
  logic bclk_fall;
  logic lrclk_rise;
  logic lrclk_fall;
  logic mute;
  logic loopback;

  i2s_clock_gen clock_gen_i (
    .clk_i, .rst_ni,
    .ac_mclk, .ac_bclk, .ac_lrclk,
    .lrclk,
    .bclk_rise, .bclk_fall,
    .lrclk_rise, .lrclk_fall
  );

  i2s_receiver receiver_i (
    .clk_i, .rst_ni,
    .ac_adc_sdata,
    .lrclk, .bclk_rise, .lrclk_rise, .lrclk_fall,
    .rx_data, .rx_valid, .rx_right
  );

  // Loopback source is the last received sample
  i2s_transmitter transmitter_i (
    .clk_i, .rst_ni,
    .tx_data, .tx_valid,
    .rx_data,
    .mute, .loopback,
    .bclk_fall, .lrclk_rise, .lrclk_fall,
    .ac_dac_sdata
  );

  audio_ctrl_regs ctrl_regs_i (
    .clk_i, .rst_ni,
    .cfg_we, .cfg_addr, .cfg_wdata,
    .rx_valid,
    .cfg_rdata, .mute, .loopback
  );

endmodule

// File: bench/i2s_codec_props.sv
`timescale 1ns/1ps

module i2s_codec_props (
  input logic               clk_i,
  input logic               rst_ni,
  input logic               ac_mclk,
  input logic               ac_bclk,
  input logic               ac_lrclk,
  input logic               ac_dac_sdata,
  input logic               rx_valid,
  input logic               rx_right,
  input audio_pkg::sample_t rx_data,
  input logic [7:0]         cfg_rdata
);

  logic [4:0] age;  // Cycles since reset, stops at 16

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) age <= '0;
    else if (!age[4]) age <= age + 5'd1;
  end

  assert property (@(posedge clk_i) disable iff (!rst_ni) rx_valid |=> !rx_valid)
    else $error("rx_valid stayed high for more than one cycle");

  // Bit clock flips every 8 cycles and never earlier
  assert property (@(posedge clk_i) disable iff (!rst_ni) age[4] |-> ac_bclk != $past(ac_bclk, 8))
    else $error("ac_bclk did not toggle after 8 cycles");
  assert property (@(posedge clk_i) disable iff (!rst_ni)
                   $changed(ac_bclk) |-> $past(ac_bclk, 1) == $past(ac_bclk, 8))
    else $error("ac_bclk changed level before 8 cycles");

  assert property (@(posedge clk_i) disable iff (!rst_ni) $changed(ac_lrclk) |-> $changed(ac_bclk))
    else $error("ac_lrclk moved without ac_bclk");

  assert property (@(posedge clk_i) disable iff (!rst_ni)
                   !$isunknown({ac_mclk, ac_bclk, ac_lrclk, ac_dac_sdata,
                                rx_valid, rx_right, rx_data, cfg_rdata}))
    else $error("unknown value on a DUT output");

endmodule

bind i2s_codec_top i2s_codec_props props_i (
  .clk_i        (clk_i),
  .rst_ni       (rst_ni),
  .ac_mclk      (ac_mclk),
  .ac_bclk      (ac_bclk),
  .ac_lrclk     (ac_lrclk),
  .ac_dac_sdata (ac_dac_sdata),
  .rx_valid     (rx_valid),
  .rx_right     (rx_right),
  .rx_data      (rx_data),
  .cfg_rdata    (cfg_rdata)
);

// File: bench/i2s_codec_tb.sv
`timescale 1ns/1ps

`include "audio_defines.svh"

module i2s_codec_tb;

  import audio_pkg::*;

  localparam int N_HALF_FRAMES  = 40;
  // Whole run plus a quarter of margin
  localparam int TIMEOUT_CYCLES = (16 + N_HALF_FRAMES * `AUDIO_LRCLK_HALF) * 5 / 4;

  logic       clk_i;
  logic       rst_ni;
  logic       ac_mclk, ac_bclk, ac_lrclk;
  logic       ac_adc_sdata;
  logic       ac_dac_sdata;
  fir_word_t  tx_data;
  logic       tx_valid;
  sample_t    rx_data;
  logic       rx_valid, rx_right;
  logic       cfg_we;
  reg_addr_e  cfg_addr;
  logic [7:0] cfg_wdata, cfg_rdata;

  // Codec model and reference model state
  int          hf_count  = 0;
  int          rise_n    = 99;  // Parked until the first frame edge
  int          fall_n    = 99;
  int          rx_pulses = 0;
  int          err_count = 0;
  int          n_checks  = 0;
  logic        bclk_d    = 1'b0;
  logic        lrclk_d   = 1'b0;
  logic        mclk_exp  = 1'b0;  // Master clock level due at this falling edge
  logic        adc_bit   = 1'b0;
  sample_t     adc_word  = '0;
  sample_t     last_rx   = '0;
  sample_t     dac_word  = '0;
  logic        mdl_mute  = 1'b0;
  logic        mdl_loop  = 1'b0;
  logic        mdl_pending = 1'b0;
  fir_word_t   mdl_held  = '0;
  logic [32:0] mdl_shift = '0;

  i2s_codec_top dut_i (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  task automatic check(input logic [31:0] exp, input logic [31:0] act, input string msg);
    n_checks++;
    if (act !== exp) begin
      err_count++;
      $display("CHECK FAILED at %0d ns: %s, expected %0h, got %0h", $time, msg, exp, act);
    end
  endtask

  task automatic write_reg(input reg_addr_e addr, input logic [7:0] data);
    @(posedge clk_i);
    cfg_we    <= 1'b1;
    cfg_addr  <= addr;
    cfg_wdata <= data;
    @(posedge clk_i);
    cfg_we <= 1'b0;
  endtask

  task automatic read_reg(input reg_addr_e addr, output logic [7:0] data);
    @(posedge clk_i);
    cfg_addr <= addr;
    @(negedge clk_i);
    data = cfg_rdata;  // Combinational read has settled by now
  endtask

  task automatic set_mode(input logic [1:0] mode);
    logic [7:0] rd;
    write_reg(REG_CTRL, {6'($urandom), mode});  // Upper bits carry noise
    read_reg(REG_CTRL, rd);
    check(32'(mode), 32'(rd), "REG_CTRL readback");
  endtask

  task automatic send_tx(input fir_word_t word);
    repeat (60) @(posedge clk_i);
    tx_data  <= word;
    tx_valid <= 1'b1;
    @(posedge clk_i);
    tx_valid <= 1'b0;
  endtask

  // ADC line changes one cycle after the model picks the bit
  initial begin
    ac_adc_sdata = 1'b0;
    forever begin
      @(posedge clk_i);
      ac_adc_sdata <= adc_bit;
    end
  end

  // Codec side and expected values are evaluated where outputs are stable
  initial begin
    forever begin
      @(negedge clk_i);
      if (rst_ni) begin
        check(32'(mclk_exp), 32'(ac_mclk), "ac_mclk");
        mclk_exp = ~mclk_exp;
        if (ac_lrclk != lrclk_d) begin
          if (hf_count > 0) check(32'd1, 32'(rx_pulses), "rx_valid pulses per half frame");
          hf_count++;
          rx_pulses = 0;
          rise_n = 0;
          fall_n = 0;
          last_rx = adc_word;  // Sample received in the half frame that ended
          adc_word = 16'($urandom);
          mdl_shift = mdl_shift << 31;  // Falls of the finished half frame
          if (mdl_mute) begin
            mdl_shift = '0;
          end else if (mdl_loop) begin
            mdl_shift = {1'b0, last_rx, 16'h0};
          end else if (mdl_pending) begin
            mdl_shift = {1'b0, mdl_held};
            mdl_pending = 1'b0;
          end
        end else if (ac_bclk && !bclk_d) begin
          rise_n++;
          if (rise_n >= 2 && rise_n <= 17) dac_word = {dac_word[14:0], ac_dac_sdata};
          if (rise_n == 17) check(32'(mdl_shift[31:16]), 32'(dac_word), "DAC word");
        end else if (!ac_bclk && bclk_d) begin
          fall_n++;
        end
        if (rx_valid) begin
          rx_pulses++;
          check(32'(adc_word), 32'(rx_data), "rx_data");
          check(32'(ac_lrclk), 32'(rx_right), "rx_right");
        end
        // Inputs seen here reach the DUT on the next edge
        if (tx_valid) begin
          mdl_pending = 1'b1;
          mdl_held = tx_data;
        end
        if (cfg_we && cfg_addr == REG_CTRL) begin
          mdl_mute = cfg_wdata[0];
          mdl_loop = cfg_wdata[1];
        end
        adc_bit = (fall_n >= 1 && fall_n <= 16) ? adc_word[4'(16 - fall_n)] : 1'b0;
        bclk_d = ac_bclk;
        lrclk_d = ac_lrclk;
      end
    end
  end

  initial begin
    int cycles;
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("ERROR: timeout, the run did not end within %0d cycles", TIMEOUT_CYCLES);
    $display(">>> FAIL");
    $finish;
  end

  initial begin
    logic [7:0] rd;
    void'($urandom(99));
    rst_ni    = 1'b0;
    tx_data   = '0;
    tx_valid  = 1'b0;
    cfg_we    = 1'b0;
    cfg_addr  = REG_CTRL;
    cfg_wdata = '0;
    repeat (16) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    check(32'd0, 32'({ac_mclk, ac_bclk, ac_lrclk, ac_dac_sdata, rx_valid, rx_right, rx_data}),
          "outputs after reset");
    // Both reads finish well before the first bit clock strobe
    read_reg(REG_CTRL, rd);
    check(32'd0, 32'(rd), "REG_CTRL after reset");
    read_reg(REG_COUNT, rd);
    check(32'd0, 32'(rd), "REG_COUNT after reset");

    for (int i = 1; i < N_HALF_FRAMES; i++) begin
      wait (hf_count >= i);
      repeat (40) @(posedge clk_i);
      read_reg(REG_COUNT, rd);
      check(32'((i - 1) % 256), 32'(rd), "REG_COUNT");
      case (i)
        14: set_mode(2'b01);  // Mute
        18: set_mode(2'b11);  // Mute over loopback
        22: set_mode(2'b10);  // Loopback
        32: set_mode(2'b00);
        default: ;
      endcase
      if (i == 30) begin
        write_reg(REG_COUNT, 8'($urandom));
        read_reg(REG_COUNT, rd);
        check(32'((i - 1) % 256), 32'(rd), "REG_COUNT after write");
      end
      repeat ($urandom % 3) send_tx($urandom);
    end
    wait (hf_count >= N_HALF_FRAMES);
    repeat (300) @(posedge clk_i);  // Let the last half frame finish its checks

    $display("Run complete: %0d checks, %0d errors", n_checks, err_count);
    if (err_count == 0) $display(">>> PASS");
    else $display(">>> FAIL");
    $finish;
  end

endmodule

// File: list.f
+incdir+src
src/audio_pkg.sv
src/i2s_clock_gen.sv
src/i2s_receiver.sv
src/i2s_transmitter.sv
src/audio_ctrl_regs.sv
src/i2s_codec_top.sv
bench/i2s_codec_props.sv
bench/i2s_codec_tb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = i2s_codec_tb
FILELIST = list.f
OBJ_DIR  = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# Passes only when the simulation prints the pass line
run: compile
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf $(OBJ_DIR)
